// File: source/div_pkg.sv
package div_pkg;

    // Operand and result width.
    localparam int DATA_WIDTH = 32;

    // A bit position plus a sign bit. The step count goes negative when a divide ends early.
    localparam int SHIFT_WIDTH = 6;

    localparam int TAG_WIDTH = 4;

    // The pipeline also holds this many credits after reset.
    localparam int NUM_CORES = 2;
    localparam int CORE_INDEX_WIDTH = 1;

    // Word operations of the divide unit.
    // Division truncates toward zero, and a remainder takes the sign of the dividend.
    // Division by zero gives quotient 0 and a remainder equal to the dividend.
    // The most negative value divided by minus one gives the dividend back, remainder 0.
    typedef enum logic [1:0] {
        DIV_S,
        MOD_S,
        DIV_U,
        MOD_U
    } div_op_e;

    typedef struct packed {
        div_op_e               op;
        logic [TAG_WIDTH-1:0]  tag;      // Returned unchanged with the result.
        logic [DATA_WIDTH-1:0] dividend;
        logic [DATA_WIDTH-1:0] divisor;
    } div_req_t;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]  tag;
        logic [DATA_WIDTH-1:0] data;     // Quotient or remainder, chosen by op.
    } div_resp_t;

endpackage

// File: source/leading_one.sv
`timescale 1ns/1ps

// Position of the highest set bit, found by halving the word five times.
module leading_one import div_pkg::*;
(
    input  logic [DATA_WIDTH-1:0] value,
    output logic [4:0]            position
);

    logic [15:0] half16;
    logic [7:0]  half8;
    logic [3:0]  half4;
    logic [1:0]  half2;

    always_comb
    begin
        position[4] = |value[31:16];
        half16 = position[4] ? value[31:16] : value[15:0];

        position[3] = |half16[15:8];
        half8 = position[3] ? half16[15:8] : half16[7:0];

        position[2] = |half8[7:4];
        half4 = position[2] ? half8[7:4] : half8[3:0];

        position[1] = |half4[3:2];
        half2 = position[1] ? half4[3:2] : half4[1:0];

        position[0] = half2[1]; // A zero word ends up at position 0.
    end

endmodule

// File: source/div_core.sv
`timescale 1ns/1ps

module div_core import div_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  div_req_t  req,
    input  logic      grant,
    output logic      busy,
    output logic      done,
    output div_resp_t result
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_ALIGN,
        S_ITERATE,
        S_HOLD
    } state_e;

    state_e                 state;
    state_e                 state_next;
    div_op_e                op_q;
    logic [TAG_WIDTH-1:0]   tag_q;
    logic [DATA_WIDTH-1:0]  remainder_q;
    logic [DATA_WIDTH-1:0]  divisor_q;
    logic [DATA_WIDTH-1:0]  quotient_q;
    logic [SHIFT_WIDTH-1:0] count_q;
    logic                   dividend_neg;
    logic                   divisor_neg;
    div_resp_t              result_q;

    logic                   is_signed;
    logic [4:0]             rem_pos;
    logic [4:0]             div_pos;
    logic [SHIFT_WIDTH-1:0] step_count;
    logic [DATA_WIDTH:0]    trial;
    logic                   finish;
    logic [DATA_WIDTH-1:0]  quotient_final;
    logic [DATA_WIDTH-1:0]  remainder_final;
    logic [DATA_WIDTH-1:0]  final_data;

    leading_one i_rem_lead
    (
        .value    (remainder_q),
        .position (rem_pos)
    );

    leading_one i_div_lead
    (
        .value    (divisor_q),
        .position (div_pos)
    );

    assign is_signed  = (op_q == DIV_S) || (op_q == MOD_S);
    assign step_count = {1'b0, rem_pos} - {1'b0, div_pos};

    // Trial subtraction of the divisor shifted up to the current quotient bit.
    assign trial = {1'b0, remainder_q} - ({1'b0, divisor_q} << count_q[SHIFT_WIDTH-2:0]);

    // Align ends early on a zero divisor or a divisor above the dividend.
    assign finish = ((state == S_ALIGN) && ((divisor_q == '0) || step_count[SHIFT_WIDTH-1]))
                 || ((state == S_ITERATE) && count_q[SHIFT_WIDTH-1]);

    assign quotient_final  = (dividend_neg ^ divisor_neg) ? -quotient_q : quotient_q;
    assign remainder_final = dividend_neg ? -remainder_q : remainder_q;
    assign final_data = ((op_q == DIV_S) || (op_q == DIV_U)) ? quotient_final : remainder_final;

    always_comb
    begin
        state_next = state;
        case (state)
            S_IDLE:    if (start) state_next = S_LOAD;
            S_LOAD:    state_next = S_ALIGN;
            S_ALIGN:   state_next = finish ? S_HOLD : S_ITERATE;
            S_ITERATE: if (finish) state_next = S_HOLD;
            S_HOLD:    if (grant) state_next = S_IDLE;
            default:   state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= S_IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge clk)
    begin
        case (state)
            S_IDLE:
            begin
                if (start)
                begin
                    op_q        <= req.op;
                    tag_q       <= req.tag;
                    remainder_q <= req.dividend; // Raw operands until load.
                    divisor_q   <= req.divisor;
                end
            end
            S_LOAD:
            begin
                dividend_neg <= is_signed && remainder_q[DATA_WIDTH-1];
                divisor_neg  <= is_signed && divisor_q[DATA_WIDTH-1];
                if (is_signed && remainder_q[DATA_WIDTH-1])
                    remainder_q <= -remainder_q;
                if (is_signed && divisor_q[DATA_WIDTH-1])
                    divisor_q <= -divisor_q;
                quotient_q <= '0;
            end
            S_ALIGN:
            begin
                count_q <= step_count;
            end
            S_ITERATE:
            begin
                if (!finish)
                begin
                    count_q    <= count_q - 1'b1;
                    quotient_q <= {quotient_q[DATA_WIDTH-2:0], ~trial[DATA_WIDTH]};
                    if (!trial[DATA_WIDTH])
                        remainder_q <= trial[DATA_WIDTH-1:0];
                end
            end
            default:
            begin
            end
        endcase

        if (finish)
        begin
            result_q.tag  <= tag_q;
            result_q.data <= final_data;
        end
    end

    assign busy   = (state != S_IDLE);
    assign done   = (state == S_HOLD);
    assign result = result_q;

    // The arbiter may only pick a core that is holding a finished result.
    grant_needs_done: assert property (@(posedge clk) disable iff (reset) grant |-> done);

    // The dispatcher must never restart a core in the middle of an operation.
    start_needs_idle: assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

// File: source/div_dispatch.sv
`timescale 1ns/1ps

module div_dispatch import div_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req_valid,
    input  div_req_t             req,
    input  logic [NUM_CORES-1:0] core_busy,
    input  logic                 resp_valid,
    output logic [NUM_CORES-1:0] core_start,
    output div_req_t             core_req
);

    logic [NUM_CORES-1:0]      core_free;
    logic [NUM_CORES-1:0]      pick;
    logic [CORE_INDEX_WIDTH:0] outstanding;

    // A core started in the previous cycle does not show busy yet.
    assign core_free = ~core_busy & ~core_start;
    assign pick      = core_free & (~core_free + 1'b1); // Lowest free core.

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            core_start  <= '0;
            outstanding <= '0;
        end
        else
        begin
            core_start <= req_valid ? pick : '0;
            case ({req_valid, resp_valid})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_valid)
            core_req <= req;
    end

    // With credits honoured there is always a free core for a request.
    req_has_core: assert property (@(posedge clk) disable iff (reset)
        req_valid |-> |core_free);

    // A count above the core count means the pipeline spent more credits than it had.
    credits_respected: assert property (@(posedge clk) disable iff (reset)
        outstanding <= NUM_CORES);

endmodule

// File: source/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter import div_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [NUM_CORES-1:0] core_done,
    input  div_resp_t            core_result [NUM_CORES],
    output logic [NUM_CORES-1:0] grant,
    output logic                 resp_valid,
    output div_resp_t            resp,
    output logic                 credit_return
);

    logic [CORE_INDEX_WIDTH-1:0] last_q;
    logic [CORE_INDEX_WIDTH-1:0] winner;

    // Search starts just past the last winner, so a waiting core is served next.
    always_comb
    begin
        int idx;
        grant  = '0;
        winner = last_q;
        for (int i = 1; i <= NUM_CORES; i++)
        begin
            idx = (int'(last_q) + i) % NUM_CORES;
            if (core_done[idx] && (grant == '0))
            begin
                grant[idx] = 1'b1;
                winner     = CORE_INDEX_WIDTH'(idx);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            resp_valid <= 1'b0;
            last_q     <= CORE_INDEX_WIDTH'(NUM_CORES - 1); // Core 0 goes first.
        end
        else
        begin
            resp_valid <= |grant;
            if (|grant)
                last_q <= winner;
        end
    end

    always_ff @(posedge clk)
    begin
        if (|grant)
            resp <= core_result[winner];
    end

    assign credit_return = resp_valid; // Each result frees one core.

    grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant));

endmodule

// File: source/div_unit.sv
`timescale 1ns/1ps

module div_unit import div_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      req_valid,
    input  div_req_t  req,
    output logic      resp_valid,
    output div_resp_t resp,
    output logic      credit_return
);

    logic [NUM_CORES-1:0] core_start;
    logic [NUM_CORES-1:0] core_busy;
    logic [NUM_CORES-1:0] core_done;
    logic [NUM_CORES-1:0] core_grant;
    div_req_t             core_req;
    div_resp_t            core_result [NUM_CORES];

    div_dispatch i_dispatch
    (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .core_busy  (core_busy),
        .resp_valid (resp_valid), // Closes the outstanding count.
        .core_start (core_start),
        .core_req   (core_req)
    );

    for (genvar c = 0; c < NUM_CORES; c++)
    begin : g_core
        div_core i_core
        (
            .clk    (clk),
            .reset  (reset),
            .start  (core_start[c]),
            .req    (core_req),
            .grant  (core_grant[c]),
            .busy   (core_busy[c]),
            .done   (core_done[c]),
            .result (core_result[c])
        );
    end

    wb_arbiter i_arbiter
    (
        .clk           (clk),
        .reset         (reset),
        .core_done     (core_done),
        .core_result   (core_result),
        .grant         (core_grant),
        .resp_valid    (resp_valid),
        .resp          (resp),
        .credit_return (credit_return)
    );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
(
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD = 10;
    localparam int RESET_CYCLES = 5;

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 reset = 1'b0; // Released just after an edge, like every other input.
    end

endmodule

// File: test/div_unit_tb.sv
`timescale 1ns/1ps

module div_unit_tb import div_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int NUM_DIRECTED = 8;
    localparam int NUM_RANDOM = 300;
    localparam int NUM_REQUESTS = NUM_DIRECTED + NUM_RANDOM;
    localparam int WATCHDOG_CYCLES = NUM_REQUESTS * 40 + 200;
    localparam int NUM_TAGS = 1 << TAG_WIDTH;
    localparam logic [DATA_WIDTH-1:0] MOST_NEG = {1'b1, {(DATA_WIDTH-1){1'b0}}};

    logic      clk;
    logic      reset;
    logic      req_valid;
    div_req_t  req;
    logic      resp_valid;
    div_resp_t resp;
    logic      credit_return;

    logic [31:0]           rng_state = 32'hfad9;
    logic                  pending [NUM_TAGS];
    logic [DATA_WIDTH-1:0] expected_data [NUM_TAGS];
    int credits = NUM_CORES;
    int issued = 0;
    int received = 0;
    int both_busy_cycles = 0;
    int data_errors = 0;
    int protocol_errors = 0;

    tb_clock i_clock
    (
        .clk   (clk),
        .reset (reset)
    );

    div_unit i_dut
    (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .resp_valid    (resp_valid),
        .resp          (resp),
        .credit_return (credit_return)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // A quarter of the operands are corner values.
    function automatic logic [DATA_WIDTH-1:0] random_operand();
        logic [31:0] r;
        r = next_rand();
        if (r[1:0] != 2'b00)
            return next_rand();
        case (next_rand() % 5)
            0:       return '0;
            1:       return 32'd1;
            2:       return '1;
            3:       return MOST_NEG;
            default: return next_rand() % 16;
        endcase
    endfunction

    // Reference model built directly from the arithmetic rules.
    function automatic logic [DATA_WIDTH-1:0] model_result(input div_op_e op,
        input logic [DATA_WIDTH-1:0] dividend, input logic [DATA_WIDTH-1:0] divisor);
        logic                  is_div;
        logic                  is_signed;
        logic [DATA_WIDTH-1:0] quotient;
        logic [DATA_WIDTH-1:0] remainder;
        is_div    = (op == DIV_S) || (op == DIV_U);
        is_signed = (op == DIV_S) || (op == MOD_S);
        if (divisor == '0)
        begin
            quotient  = '0;
            remainder = dividend;
        end
        else if (is_signed && (dividend == MOST_NEG) && (divisor == '1))
        begin
            quotient  = dividend;
            remainder = '0;
        end
        else if (is_signed)
        begin
            quotient  = $signed(dividend) / $signed(divisor); // Truncates toward zero.
            remainder = $signed(dividend) % $signed(divisor);
        end
        else
        begin
            quotient  = dividend / divisor;
            remainder = dividend % divisor;
        end
        return is_div ? quotient : remainder;
    endfunction

    function automatic logic [TAG_WIDTH-1:0] free_tag(input logic [TAG_WIDTH-1:0] first);
        logic [TAG_WIDTH-1:0] tag;
        tag = first;
        for (int i = 0; i < NUM_TAGS; i++)
        begin
            if (!pending[tag])
                return tag;
            tag = tag + 1'b1;
        end
        return first;
    endfunction

    task automatic check_resp(input div_resp_t actual, input div_resp_t expected);
        if (actual !== expected)
        begin
            $display("[FAIL] %0t ns resp: got tag %0d data %h, expected tag %0d data %h",
                $time, actual.tag, actual.data, expected.tag, expected.data);
            data_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, actual, expected);
            protocol_errors++;
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        if (actual != expected)
        begin
            $display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, name, actual, expected);
            protocol_errors++;
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
        req_valid = 1'b0;
    endtask

    // Waits for a credit, then holds the request for exactly one cycle.
    task automatic send_request(input div_op_e op, input logic [DATA_WIDTH-1:0] dividend,
        input logic [DATA_WIDTH-1:0] divisor);
        logic [TAG_WIDTH-1:0] tag;
        logic [31:0]          r;
        idle_cycle();
        while (credits == 0)
            idle_cycle();
        r   = next_rand();
        tag = free_tag(r[TAG_WIDTH-1:0]);
        expected_data[tag] = model_result(op, dividend, divisor);
        pending[tag] = 1'b1;
        req.op       = op;
        req.tag      = tag;
        req.dividend = dividend;
        req.divisor  = divisor;
        req_valid    = 1'b1;
        credits--;
        issued++;
    endtask

    // Outputs are sampled at the falling edge, half a period away from any update.
    always @(negedge clk)
    begin
        if (!reset)
        begin
            check_flag("credit_return", credit_return, resp_valid);
            if (issued == 0)
                check_flag("resp_valid", resp_valid, 1'b0);
            if (resp_valid === 1'b1)
            begin
                if (pending[resp.tag] !== 1'b1)
                begin
                    $display("Response at %0t ns carries tag %0d, which is not outstanding.",
                        $time, resp.tag);
                    protocol_errors++;
                end
                else
                begin
                    check_resp(resp, '{tag: resp.tag, data: expected_data[resp.tag]});
                    pending[resp.tag] = 1'b0;
                end
                received++;
            end
            if (credit_return === 1'b1)
                credits++;
            if (i_dut.core_busy == '1)
                both_busy_cycles++;
        end
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles with %0d of %0d responses received.",
            WATCHDOG_CYCLES, received, issued);
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        logic [31:0] r;
        div_op_e     op;
        req_valid = 1'b0;
        req       = '0;
        for (int i = 0; i < NUM_TAGS; i++)
            pending[i] = 1'b0;
        @(negedge reset);
        repeat (10) idle_cycle(); // Outputs must stay quiet before the first request.

        send_request(DIV_S, 32'd100, '0);
        send_request(MOD_S, -32'sd7, '0);
        send_request(DIV_U, '1, '0);
        send_request(MOD_U, 32'd12345, '0);
        send_request(DIV_S, MOST_NEG, '1);
        send_request(MOD_S, MOST_NEG, '1);
        send_request(DIV_S, -32'sd7, 32'd2);
        send_request(MOD_S, -32'sd7, 32'd2);

        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            r = next_rand();
            if (r[1:0] == 2'b00)
                idle_cycle();
            op = div_op_e'(r[3:2]);
            send_request(op, random_operand(), random_operand());
        end
        idle_cycle();

        while (received < issued)
            @(posedge clk);
        repeat (3) @(posedge clk);
        check_count("credits", credits, NUM_CORES);
        check_count("responses", received, issued);
        if (both_busy_cycles == 0)
        begin
            $display("The two cores never worked in the same cycle.");
            protocol_errors++;
        end

        $display("Errors: data %0d, protocol %0d; requests %0d, responses %0d",
            data_errors, protocol_errors, issued, received);
        if (data_errors + protocol_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: list.f
source/div_pkg.sv
source/leading_one.sv
source/div_core.sv
source/div_dispatch.sv
source/wb_arbiter.sv
source/div_unit.sv
test/tb_clock.sv
test/div_unit_tb.sv

// File: Makefile
TOOL       ?= verilator
FLAGS      ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= div_unit_tb
FILE_LIST  ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_TEXT  := FAIL: see errors above

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); test $$status -eq 0
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "Simulation failed."; exit 1; fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
